//--- logic/ps2_pkg.sv
package ps2_pkg;

    // ########################################################################
    // Data widths
    // ########################################################################

    typedef logic [7:0] scan_code_t;

    // Zero means the last key had no printable character
    typedef logic [7:0] ascii_t;

    typedef logic [7:0] press_count_t;

    // Segments a to g sit in bits 0 to 6 and the decimal point in bit 7, all active low
    typedef logic [7:0] seg_t;

    // ########################################################################
    // Key tracker states
    // ########################################################################

    typedef enum logic [2:0] {
        idle,
        read_make,
        pop_make,
        wait_break,
        read_break,
        pop_break
    } tracker_state_t;

    // ########################################################################
    // Constants
    // ########################################################################

    localparam scan_code_t break_prefix     = 8'hf0;
    localparam scan_code_t shift_left_code  = 8'h12;
    localparam scan_code_t shift_right_code = 8'h59;

    localparam int fifo_depth  = 8;
    localparam int fifo_addr_w = $clog2(fifo_depth);
    localparam int filter_len  = 4;

endpackage

//--- logic/ps2_receiver.sv
module ps2_receiver
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    input  logic                nextdata_n,
    output ps2_pkg::scan_code_t data,
    output logic                ready,
    output logic                overflow
);
    import ps2_pkg::*;

    logic                  clk_s1;
    logic                  clk_s2;
    logic                  dat_s1;
    logic                  dat_s2;
    logic [filter_len-2:0] clk_hist;
    logic [filter_len-1:0] clk_window;
    logic                  clk_level;
    logic                  fall;
    logic [9:0]            frame;
    logic [3:0]            bit_cnt;
    logic                  frame_ok;
    logic                  push;
    logic                  full;
    logic [fifo_addr_w:0]  w_ptr;
    logic [fifo_addr_w:0]  r_ptr;
    scan_code_t            fifo_mem [fifo_depth];

    // ########################################################################
    // Line synchronizers and clock filter
    // ########################################################################

    // The filtered level only follows ps2_clk once the whole window agrees
    assign clk_window = {clk_hist, clk_s2};
    assign fall       = clk_level && (clk_window == '0);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_s1    <= 1'b1;
            clk_s2    <= 1'b1;
            dat_s1    <= 1'b1;
            dat_s2    <= 1'b1;
            clk_hist  <= '1;
            clk_level <= 1'b1;
        end
        else
        begin
            clk_s1   <= ps2_clk;
            clk_s2   <= clk_s1;
            dat_s1   <= ps2_dat;
            dat_s2   <= dat_s1;
            clk_hist <= {clk_hist[filter_len-3:0], clk_s2};
            if (&clk_window)
                clk_level <= 1'b1;
            else if (fall)
                clk_level <= 1'b0;
        end
    end

    // ########################################################################
    // Frame shifter
    // ########################################################################

    // After ten edges frame holds start, data and parity, and the stop bit is on the line
    assign frame_ok = !frame[0] && (^frame[9:1]) && dat_s2;
    assign push     = fall && (bit_cnt == 4'd10) && frame_ok;

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= {dat_s2, frame[9:1]};
    end

    // ########################################################################
    // Byte FIFO
    // ########################################################################

    assign full  = (w_ptr[fifo_addr_w] != r_ptr[fifo_addr_w]) &&
                   (w_ptr[fifo_addr_w-1:0] == r_ptr[fifo_addr_w-1:0]);
    assign ready = (w_ptr != r_ptr);
    assign data  = fifo_mem[r_ptr[fifo_addr_w-1:0]];

    always_ff @(posedge clk)
    begin
        if (push && !full)
            fifo_mem[w_ptr[fifo_addr_w-1:0]] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt  <= 4'd0;
            w_ptr    <= '0;
            r_ptr    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (fall)
                bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
            if (push && full)
                overflow <= 1'b1;
            else if (push)
                w_ptr <= w_ptr + 1'b1;
            if (!nextdata_n && ready)
                r_ptr <= r_ptr + 1'b1;
        end
    end

endmodule

//--- logic/key_tracker.sv
module key_tracker
(
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::scan_code_t data,
    input  logic                ready,
    input  logic                overflow,
    output logic                nextdata_n,
    output logic                make_valid,
    output ps2_pkg::scan_code_t make_code,
    output logic                break_valid,
    output ps2_pkg::scan_code_t break_code,
    output ps2_pkg::scan_code_t released_code,
    output logic                key_seen
);
    import ps2_pkg::*;

    tracker_state_t state;
    tracker_state_t state_next;
    logic           avail;

    assign avail = ready && !overflow;

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
                if (avail)
                    state_next = read_make;
            read_make:
                state_next = (data == break_prefix) ? wait_break : pop_make;
            pop_make:
                state_next = idle;
            // The first cycle here pops the F0 byte, so ready is stale until it ends
            wait_break:
                if (avail && nextdata_n)
                    state_next = read_break;
            read_break:
                state_next = pop_break;
            pop_break:
                state_next = idle;
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state         <= idle;
            nextdata_n    <= 1'b1;
            make_valid    <= 1'b0;
            break_valid   <= 1'b0;
            released_code <= '0;
            key_seen      <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            nextdata_n  <= !(state == read_make || state == read_break);
            make_valid  <= (state == read_make) && (data != break_prefix);
            break_valid <= (state == read_break);
            if (state == read_break)
            begin
                released_code <= data;
                key_seen      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == read_make)
            make_code <= data;
        if (state == read_break)
            break_code <= data;
    end

endmodule

//--- logic/ascii_lookup.sv
module ascii_lookup
(
    input  logic                clk,
    input  logic                rst,
    input  logic                make_valid,
    input  ps2_pkg::scan_code_t make_code,
    input  logic                break_valid,
    input  ps2_pkg::scan_code_t break_code,
    output ps2_pkg::ascii_t     ascii
);
    import ps2_pkg::*;

    logic   shift_l;
    logic   shift_r;
    ascii_t base;
    logic   is_lower;

    // Set-2 codes of letters, digits and space, letters in lower case
    function automatic ascii_t code_to_ascii(input scan_code_t code);
        case (code)
            8'h1c: return 8'h61;
            8'h32: return 8'h62;
            8'h21: return 8'h63;
            8'h23: return 8'h64;
            8'h24: return 8'h65;
            8'h2b: return 8'h66;
            8'h34: return 8'h67;
            8'h33: return 8'h68;
            8'h43: return 8'h69;
            8'h3b: return 8'h6a;
            8'h42: return 8'h6b;
            8'h4b: return 8'h6c;
            8'h3a: return 8'h6d;
            8'h31: return 8'h6e;
            8'h44: return 8'h6f;
            8'h4d: return 8'h70;
            8'h15: return 8'h71;
            8'h2d: return 8'h72;
            8'h1b: return 8'h73;
            8'h2c: return 8'h74;
            8'h3c: return 8'h75;
            8'h2a: return 8'h76;
            8'h1d: return 8'h77;
            8'h22: return 8'h78;
            8'h35: return 8'h79;
            8'h1a: return 8'h7a;
            8'h45: return 8'h30;
            8'h16: return 8'h31;
            8'h1e: return 8'h32;
            8'h26: return 8'h33;
            8'h25: return 8'h34;
            8'h2e: return 8'h35;
            8'h36: return 8'h36;
            8'h3d: return 8'h37;
            8'h3e: return 8'h38;
            8'h46: return 8'h39;
            8'h29: return 8'h20;
            default: return 8'h00;
        endcase
    endfunction

    assign base     = code_to_ascii(make_code);
    assign is_lower = (base >= 8'h61) && (base <= 8'h7a);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            shift_l <= 1'b0;
            shift_r <= 1'b0;
            ascii   <= '0;
        end
        else
        begin
            if (make_valid)
            begin
                if (make_code == shift_left_code)
                    shift_l <= 1'b1;
                else if (make_code == shift_right_code)
                    shift_r <= 1'b1;
                else if ((shift_l || shift_r) && is_lower)
                    ascii <= base - 8'h20;
                else
                    ascii <= base;
            end
            if (break_valid && break_code == shift_left_code)
                shift_l <= 1'b0;
            if (break_valid && break_code == shift_right_code)
                shift_r <= 1'b0;
        end
    end

endmodule

//--- logic/press_counter.sv
module press_counter
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  make_valid,
    input  ps2_pkg::scan_code_t   make_code,
    input  logic                  break_valid,
    input  ps2_pkg::scan_code_t   break_code,
    output ps2_pkg::press_count_t count
);
    import ps2_pkg::*;

    logic       held;
    scan_code_t held_code;
    logic       is_shift;
    logic       repeat_key;

    assign is_shift   = (make_code == shift_left_code) || (make_code == shift_right_code);
    // A make of the key still held down is typematic repeat
    assign repeat_key = held && (make_code == held_code);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            count <= '0;
            held  <= 1'b0;
        end
        else if (make_valid && !is_shift)
        begin
            held <= 1'b1;
            if (!repeat_key)
                count <= count + 1'b1;
        end
        else if (break_valid && held && break_code == held_code)
            held <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (make_valid && !is_shift)
            held_code <= make_code;
    end

endmodule

//--- logic/display_driver.sv
module display_driver
(
    input  logic                  clk,
    input  logic                  rst,
    input  ps2_pkg::scan_code_t   released_code,
    input  ps2_pkg::ascii_t       ascii,
    input  ps2_pkg::press_count_t count,
    input  logic                  key_seen,
    output ps2_pkg::seg_t         seg1,
    output ps2_pkg::seg_t         seg2,
    output ps2_pkg::seg_t         seg3,
    output ps2_pkg::seg_t         seg4,
    output ps2_pkg::seg_t         seg5,
    output ps2_pkg::seg_t         seg6
);
    import ps2_pkg::*;

    // Bit 7 stays high so the decimal point is dark
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst || !key_seen)
        begin
            seg1 <= '1;
            seg2 <= '1;
            seg3 <= '1;
            seg4 <= '1;
            seg5 <= '1;
            seg6 <= '1;
        end
        else
        begin
            seg1 <= hex_to_seg(released_code[3:0]);
            seg2 <= hex_to_seg(released_code[7:4]);
            seg3 <= hex_to_seg(ascii[3:0]);
            seg4 <= hex_to_seg(ascii[7:4]);
            seg5 <= hex_to_seg(count[3:0]);
            seg6 <= hex_to_seg(count[7:4]);
        end
    end

endmodule

//--- logic/ps2_key_display.sv
module ps2_key_display
(
    input  logic          clk,
    input  logic          rst,
    input  logic          ps2_clk,
    input  logic          ps2_dat,
    output ps2_pkg::seg_t seg1,
    output ps2_pkg::seg_t seg2,
    output ps2_pkg::seg_t seg3,
    output ps2_pkg::seg_t seg4,
    output ps2_pkg::seg_t seg5,
    output ps2_pkg::seg_t seg6
);
    import ps2_pkg::*;

    scan_code_t   data;
    logic         ready;
    logic         overflow;
    logic         nextdata_n;
    logic         make_valid;
    scan_code_t   make_code;
    logic         break_valid;
    scan_code_t   break_code;
    scan_code_t   released_code;
    logic         key_seen;
    ascii_t       ascii;
    press_count_t count;

    ps2_receiver ps2_receiver_i
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .data       (data),
        .ready      (ready),
        .overflow   (overflow)
    );

    key_tracker key_tracker_i
    (
        .clk           (clk),
        .rst           (rst),
        .data          (data),
        .ready         (ready),
        .overflow      (overflow),
        .nextdata_n    (nextdata_n),
        .make_valid    (make_valid),
        .make_code     (make_code),
        .break_valid   (break_valid),
        .break_code    (break_code),
        .released_code (released_code),
        .key_seen      (key_seen)
    );

    // The lookup and the counter both watch the same event stream
    ascii_lookup ascii_lookup_i
    (
        .clk         (clk),
        .rst         (rst),
        .make_valid  (make_valid),
        .make_code   (make_code),
        .break_valid (break_valid),
        .break_code  (break_code),
        .ascii       (ascii)
    );

    press_counter press_counter_i
    (
        .clk         (clk),
        .rst         (rst),
        .make_valid  (make_valid),
        .make_code   (make_code),
        .break_valid (break_valid),
        .break_code  (break_code),
        .count       (count)
    );

    display_driver display_driver_i
    (
        .clk           (clk),
        .rst           (rst),
        .released_code (released_code),
        .ascii         (ascii),
        .count         (count),
        .key_seen      (key_seen),
        .seg1          (seg1),
        .seg2          (seg2),
        .seg3          (seg3),
        .seg4          (seg4),
        .seg5          (seg5),
        .seg6          (seg6)
    );

endmodule

//--- bench/ps2_key_display_tb.sv
module ps2_key_display_tb;
    import ps2_pkg::*;

    localparam int num_frames     = 90;
    localparam int timeout_cycles = num_frames * 11 * 32 + 2000;

    // Set-2 make codes of the letters a to z
    localparam scan_code_t letter_codes [26] = '{
        8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a,
        8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a
    };

    localparam seg_t seg_table [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    logic clk;
    logic rst;
    logic ps2_clk;
    logic ps2_dat;
    seg_t seg1;
    seg_t seg2;
    seg_t seg3;
    seg_t seg4;
    seg_t seg5;
    seg_t seg6;

    // Reference model state
    scan_code_t   exp_released;
    ascii_t       exp_ascii;
    press_count_t exp_count;
    logic         exp_seen;
    logic         pending_break;
    logic         shift_l;
    logic         shift_r;
    logic         held;
    scan_code_t   held_code;
    logic [31:0]  rand_state;
    int           order [26];

    ps2_key_display ps2_key_display_i
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3),
        .seg4    (seg4),
        .seg5    (seg5),
        .seg6    (seg6)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
        $display("Test failed");
        $fatal(1);
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic ascii_t letter_ascii(input scan_code_t code, input logic shifted);
        for (int i = 0; i < 26; i++)
            if (letter_codes[i] == code)
                return (shifted ? 8'h41 : 8'h61) + 8'(i);
        return 8'h00;
    endfunction

    function automatic seg_t expected_seg(input logic [3:0] nibble);
        return exp_seen ? seg_table[nibble] : 8'hff;
    endfunction

    task automatic update_model(input scan_code_t code);
        if (pending_break)
        begin
            pending_break = 1'b0;
            exp_released  = code;
            exp_seen      = 1'b1;
            if (code == shift_left_code)
                shift_l = 1'b0;
            if (code == shift_right_code)
                shift_r = 1'b0;
            if (held && code == held_code)
                held = 1'b0;
        end
        else if (code == break_prefix)
            pending_break = 1'b1;
        else if (code == shift_left_code)
            shift_l = 1'b1;
        else if (code == shift_right_code)
            shift_r = 1'b1;
        else
        begin
            exp_ascii = letter_ascii(code, shift_l || shift_r);
            // A make of the key still held is typematic repeat
            if (!(held && code == held_code))
                exp_count = exp_count + 8'd1;
            held      = 1'b1;
            held_code = code;
        end
    endtask

    // ########################################################################
    // Stimulus and checks
    // ########################################################################

    task automatic check_seg(input string name, input seg_t actual, input seg_t expected);
        assert (actual === expected)
        else
        begin
            $display("** Error %s: expected %h, got %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_display;
        check_seg("seg1", seg1, expected_seg(exp_released[3:0]));
        check_seg("seg2", seg2, expected_seg(exp_released[7:4]));
        check_seg("seg3", seg3, expected_seg(exp_ascii[3:0]));
        check_seg("seg4", seg4, expected_seg(exp_ascii[7:4]));
        check_seg("seg5", seg5, expected_seg(exp_count[3:0]));
        check_seg("seg6", seg6, expected_seg(exp_count[7:4]));
    endtask

    // Start bit, data LSB first, odd parity, stop bit
    task automatic send_frame(input scan_code_t code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            repeat (16) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (16) @(negedge clk);
            ps2_clk = 1'b1;
        end
    endtask

    task automatic send_byte(input scan_code_t code, input logic bad_parity);
        send_frame(code, bad_parity);
        if (!bad_parity)
            update_model(code);
        repeat (12) @(negedge clk);
        check_display();
    endtask

    task automatic press_release(input scan_code_t code);
        send_byte(code, 1'b0);
        send_byte(break_prefix, 1'b0);
        send_byte(code, 1'b0);
    endtask

    initial
    begin
        int pick;
        int swap;

        rst           = 1'b0;
        ps2_clk       = 1'b1;
        ps2_dat       = 1'b1;
        exp_released  = '0;
        exp_ascii     = '0;
        exp_count     = '0;
        exp_seen      = 1'b0;
        pending_break = 1'b0;
        shift_l       = 1'b0;
        shift_r       = 1'b0;
        held          = 1'b0;
        held_code     = '0;
        rand_state    = 32'h8edd_a8c0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        check_display();

        // Blank until the first release, then press and release
        send_byte(8'h1c, 1'b0);
        send_byte(break_prefix, 1'b0);
        send_byte(8'h1c, 1'b0);
        press_release(8'h32);

        // Left shift, then right shift
        send_byte(shift_left_code, 1'b0);
        press_release(8'h21);
        send_byte(break_prefix, 1'b0);
        send_byte(shift_left_code, 1'b0);
        press_release(8'h21);
        send_byte(shift_right_code, 1'b0);
        press_release(8'h23);
        send_byte(break_prefix, 1'b0);
        send_byte(shift_right_code, 1'b0);

        // Typematic repeat counts once
        repeat (3) send_byte(8'h24, 1'b0);
        send_byte(break_prefix, 1'b0);
        send_byte(8'h24, 1'b0);

        // A parity error is dropped and the next frame is handled
        send_byte(8'h2b, 1'b1);
        press_release(8'h2b);

        for (int i = 0; i < 26; i++)
            order[i] = i;
        for (int i = 25; i > 0; i--)
        begin
            rand_state = xorshift(rand_state);
            pick        = int'(rand_state % (i + 1));
            swap        = order[i];
            order[i]    = order[pick];
            order[pick] = swap;
        end
        for (int k = 0; k < 20; k++)
            press_release(letter_codes[order[k]]);

        $display("Test passed");
        $finish;
    end

endmodule

//--- ps2_key_display.f
logic/ps2_pkg.sv
logic/ps2_receiver.sv
logic/key_tracker.sv
logic/ascii_lookup.sv
logic/press_counter.sv
logic/display_driver.sv
logic/ps2_key_display.sv
bench/ps2_key_display_tb.sv

//--- Makefile
TOP  := ps2_key_display_tb
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard logic/*.sv bench/*.sv)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

$(BIN): ps2_key_display.f $(SRCS)
	verilator --binary --assert --top-module $(TOP) -f ps2_key_display.f

clean:
	rm -rf obj_dir
